/* include/core_defines.svh */
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// interleaved slices per ADC word
`define CORE_NTI 4

// sign-magnitude code width, sign bit included
`define CORE_NADC 8

// PRBS order, polynomial x^7+x^6+1
`define CORE_NPRBS 7

// width of the correct and total bit counters
`define CORE_CNT_W 32

`endif

/* source/const_pack.sv */
`default_nettype none

`include "core_defines.svh"

package const_pack;

    // magnitude part of one ADC code
    typedef logic [`CORE_NADC-2:0] adc_code_t;

    // one raw code as delivered by a sub-ADC
    typedef struct packed {
        // set for a negative code
        logic      sign;
        adc_code_t mag;
    } adc_sample_t;

    // one word, slice 0 in the low bits
    typedef adc_sample_t [`CORE_NTI-1:0] adc_word_t;

    // two's complement value after unfolding
    typedef logic signed [`CORE_NADC-1:0] unfolded_t;

    // per-slice offsets, same ordering as adc_word_t
    typedef unfolded_t [`CORE_NTI-1:0] offset_word_t;

endpackage

`default_nettype wire

/* source/prbs_pack.sv */
`default_nettype none

`include "core_defines.svh"

package prbs_pack;

    // lock seeds the state from the data and check compares against it
    typedef enum logic {
        MODE_LOCK  = 1'b0,
        MODE_CHECK = 1'b1
    } prbs_mode_e;

    typedef struct packed {
        prbs_mode_e           mode;
        // decision level, a bit is 1 above it
        const_pack::unfolded_t thresh;
    } prbs_cfg_t;

    typedef struct packed {
        logic [`CORE_CNT_W-1:0] correct;
        logic [`CORE_CNT_W-1:0] total;
    } prbs_stat_t;

endpackage

`default_nettype wire

/* source/adc_retimer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module adc_retimer (
    input  wire logic                  clk_adc,
    input  wire logic                  rst_i,

    // word from the ADC front end
    input  wire const_pack::adc_word_t in_word_i,
    input  wire logic                  in_valid_i,
    output wire logic                  in_ready_o,

    // fan-out towards the unfolding slices
    output wire const_pack::adc_word_t lane_sample_o,
    output wire logic                  lane_valid_o,
    input  wire logic [`CORE_NTI-1:0]  lane_ready_i
);

    const_pack::adc_word_t word_q;
    logic                  valid_q;
    logic                  lanes_take;
    logic                  load;

    // slices run in lockstep, so the word leaves only when all take it
    assign lanes_take = &lane_ready_i;

    // empty, or drained by the slices this cycle
    assign in_ready_o = !valid_q || lanes_take;
    assign load       = in_valid_i && in_ready_o;

    always_ff @(posedge clk_adc) begin
        if (rst_i) begin
            valid_q <= 1'b0;
        end else if (in_ready_o) begin
            valid_q <= in_valid_i;
        end
    end

    always_ff @(posedge clk_adc) begin
        if (load) begin
            word_q <= in_word_i;
        end
    end

    // every slice sees the same valid and picks its own sample
    assign lane_sample_o = word_q;
    assign lane_valid_o  = valid_q;

endmodule

`default_nettype wire

/* source/adc_unfolding.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module adc_unfolding (
    input  wire logic                    clk_adc,
    input  wire logic                    rst_i,

    input  wire const_pack::adc_sample_t sample_i,
    input  wire logic                    valid_i,
    output wire logic                    ready_o,

    // static per-slice offset
    input  wire const_pack::unfolded_t   offset_i,

    output wire const_pack::unfolded_t   value_o,
    output wire logic                    valid_o,
    input  wire logic                    ready_i
);

    // two guard bits cover +-mag minus any offset
    localparam int WIDE_W = `CORE_NADC + 2;
    localparam logic signed [WIDE_W-1:0] SAT_MAX = (1 <<< (`CORE_NADC - 1)) - 1;
    localparam logic signed [WIDE_W-1:0] SAT_MIN = -(1 <<< (`CORE_NADC - 1));

    logic signed [WIDE_W-1:0] mag_ext;
    logic signed [WIDE_W-1:0] folded;
    logic signed [WIDE_W-1:0] diff;
    const_pack::unfolded_t    sat_value;
    const_pack::unfolded_t    value_q;
    logic                     valid_q;

    always_comb begin
        mag_ext = WIDE_W'(sample_i.mag);
        // negative zero folds onto zero
        folded  = sample_i.sign ? -mag_ext : mag_ext;
        diff    = folded - WIDE_W'(offset_i);
        if (diff > SAT_MAX) begin
            sat_value = SAT_MAX[`CORE_NADC-1:0];
        end else if (diff < SAT_MIN) begin
            sat_value = SAT_MIN[`CORE_NADC-1:0];
        end else begin
            sat_value = diff[`CORE_NADC-1:0];
        end
    end

    assign ready_o = !valid_q || ready_i;

    always_ff @(posedge clk_adc) begin
        if (rst_i) begin
            valid_q <= 1'b0;
        end else if (ready_o) begin
            valid_q <= valid_i;
        end
    end

    always_ff @(posedge clk_adc) begin
        if (valid_i && ready_o) begin
            value_q <= sat_value;
        end
    end

    assign value_o = value_q;
    assign valid_o = valid_q;

endmodule

`default_nettype wire

/* source/prbs_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module prbs_checker (
    input  wire logic                                   clk_adc,
    input  wire logic                                   rst_i,

    // one value per slice, all slices in lockstep
    input  wire const_pack::unfolded_t [`CORE_NTI-1:0]  value_i,
    input  wire logic [`CORE_NTI-1:0]                   valid_i,
    output wire logic                                   ready_o,

    input  wire prbs_pack::prbs_cfg_t                   cfg_i,

    // decided bits, bit 0 is earliest in time
    output wire logic [`CORE_NTI-1:0]                   bits_o,
    output wire logic                                   out_valid_o,
    input  wire logic                                   out_ready_i,

    output wire prbs_pack::prbs_stat_t                  stat_o
);

    localparam int NP      = `CORE_NPRBS;
    localparam int MATCH_W = $clog2(`CORE_NTI + 1);

    logic [`CORE_NTI-1:0]  dec_bits;
    logic [`CORE_NTI-1:0]  bits_q;
    logic                  out_valid_q;
    logic                  capture;
    logic [NP-1:0]         prbs_q;
    logic [NP-1:0]         prbs_nxt;
    logic                  pred;
    logic [MATCH_W-1:0]    match_cnt;
    prbs_pack::prbs_stat_t stat_q;

    // slicer against the programmable threshold
    always_comb begin
        for (int k = 0; k < `CORE_NTI; k++) begin
            dec_bits[k] = $signed(value_i[k]) > $signed(cfg_i.thresh);
        end
    end

    assign ready_o = !out_valid_q || out_ready_i;
    assign capture = (&valid_i) && ready_o;

    // walk the four bits in time order with x^7+x^6+1 taps on the two oldest bits
    always_comb begin
        prbs_nxt  = prbs_q;
        match_cnt = '0;
        pred      = 1'b0;
        for (int k = 0; k < `CORE_NTI; k++) begin
            pred = prbs_nxt[NP-1] ^ prbs_nxt[NP-2];
            if (cfg_i.mode == prbs_pack::MODE_CHECK) begin
                if (dec_bits[k] == pred) begin
                    match_cnt = match_cnt + 1'b1;
                end
                prbs_nxt = {prbs_nxt[NP-2:0], pred};
            end else begin
                // lock follows the received data
                prbs_nxt = {prbs_nxt[NP-2:0], dec_bits[k]};
            end
        end
    end

    always_ff @(posedge clk_adc) begin
        if (rst_i) begin
            out_valid_q <= 1'b0;
            prbs_q      <= '0;
            stat_q      <= '0;
        end else begin
            if (ready_o) begin
                out_valid_q <= &valid_i;
            end
            if (capture) begin
                prbs_q <= prbs_nxt;
                if (cfg_i.mode == prbs_pack::MODE_CHECK) begin
                    stat_q.correct <= stat_q.correct + `CORE_CNT_W'(match_cnt);
                    stat_q.total   <= stat_q.total + `CORE_CNT_W'(`CORE_NTI);
                end
            end
        end
    end

    always_ff @(posedge clk_adc) begin
        if (capture) begin
            bits_q <= dec_bits;
        end
    end

    assign bits_o      = bits_q;
    assign out_valid_o = out_valid_q;
    assign stat_o      = stat_q;

endmodule

`default_nettype wire

/* source/digital_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module digital_core (
    input  wire logic                     clk_adc,
    input  wire logic                     rst_i,

    input  wire const_pack::adc_word_t    in_word_i,
    input  wire logic                     in_valid_i,
    output wire logic                     in_ready_o,

    // static configuration
    input  wire const_pack::offset_word_t offsets_i,
    input  wire prbs_pack::prbs_cfg_t     cfg_i,

    output wire logic [`CORE_NTI-1:0]     bits_o,
    output wire logic                     out_valid_o,
    input  wire logic                     out_ready_i,

    output wire prbs_pack::prbs_stat_t    stat_o
);

    const_pack::adc_word_t                 lane_sample;
    logic                                  lane_valid;
    logic [`CORE_NTI-1:0]                  lane_ready;
    const_pack::unfolded_t [`CORE_NTI-1:0] slice_value;
    logic [`CORE_NTI-1:0]                  slice_valid;
    logic                                  checker_ready;

    adc_retimer u_retimer (
        .clk_adc       (clk_adc),
        .rst_i         (rst_i),
        .in_word_i     (in_word_i),
        .in_valid_i    (in_valid_i),
        .in_ready_o    (in_ready_o),
        .lane_sample_o (lane_sample),
        .lane_valid_o  (lane_valid),
        .lane_ready_i  (lane_ready)
    );

    genvar k;
    generate
        for (k = 0; k < `CORE_NTI; k++) begin : g_slice
            adc_unfolding u_unfold (
                .clk_adc  (clk_adc),
                .rst_i    (rst_i),
                .sample_i (lane_sample[k]),
                .valid_i  (lane_valid),
                .ready_o  (lane_ready[k]),
                .offset_i (offsets_i[k]),
                .value_o  (slice_value[k]),
                .valid_o  (slice_valid[k]),
                // one ready from the checker keeps the slices aligned
                .ready_i  (checker_ready)
            );
        end
    endgenerate

    prbs_checker u_checker (
        .clk_adc     (clk_adc),
        .rst_i       (rst_i),
        .value_i     (slice_value),
        .valid_i     (slice_valid),
        .ready_o     (checker_ready),
        .cfg_i       (cfg_i),
        .bits_o      (bits_o),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .stat_o      (stat_o)
    );

endmodule

`default_nettype wire

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic rst_o
);

    localparam int HALF_NS    = 4;
    localparam int RST_CYCLES = 4;

    initial begin
        clk_o = 1'b0;
        forever #(HALF_NS) clk_o = ~clk_o;
    end

    // synchronous reset, dropped on a falling edge
    initial begin
        rst_o = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b0;
    end

endmodule

`default_nettype wire

/* verification/digital_core_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module digital_core_asserts (
    input wire logic                  clk_i,
    input wire logic                  rst_i,
    input wire const_pack::adc_word_t in_word_i,
    input wire logic                  in_valid_i,
    input wire logic                  in_ready_i,
    input wire logic [`CORE_NTI-1:0]  bits_i,
    input wire logic                  out_valid_i,
    input wire logic                  out_ready_i
);

    // number of failed assertions
    int fail_cnt = 0;

    // a stalled input word holds until taken
    in_hold_a: assert property (@(posedge clk_i) disable iff (rst_i)
        in_valid_i && !in_ready_i |=> in_valid_i && $stable(in_word_i))
        else begin
            $error("input valid or word changed while in_ready_o was low");
            fail_cnt++;
        end

    // same on the bit output
    out_hold_a: assert property (@(posedge clk_i) disable iff (rst_i)
        out_valid_i && !out_ready_i |=> out_valid_i && $stable(bits_i))
        else begin
            $error("out_valid_o or bits_o changed while out_ready_i was low");
            fail_cnt++;
        end

    out_valid_known_a: assert property (@(posedge clk_i) disable iff (rst_i)
        !$isunknown(out_valid_i))
        else begin
            $error("out_valid_o is unknown after reset");
            fail_cnt++;
        end

    ready_after_reset_a: assert property (@(posedge clk_i)
        $fell(rst_i) |-> in_ready_i)
        else begin
            $error("in_ready_o is low in the first cycle after reset");
            fail_cnt++;
        end

endmodule

bind digital_core digital_core_asserts u_asserts (
    .clk_i       (clk_adc),
    .rst_i       (rst_i),
    .in_word_i   (in_word_i),
    .in_valid_i  (in_valid_i),
    .in_ready_i  (in_ready_o),
    .bits_i      (bits_o),
    .out_valid_i (out_valid_o),
    .out_ready_i (out_ready_i)
);

`default_nettype wire

/* verification/digital_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module digital_core_tb;

    localparam int CLK_NS      = 8;
    localparam int NP          = `CORE_NPRBS;
    localparam int VMAX        = (1 << (`CORE_NADC - 1)) - 1;
    localparam int VMIN        = -(1 << (`CORE_NADC - 1));
    localparam int TOTAL_WORDS = 200 + 20 + 200 + 2 * 102;
    localparam int DRAIN_MAX   = 200;

    logic                     clk;
    logic                     rst;
    const_pack::adc_word_t    in_word;
    logic                     in_valid;
    logic                     in_ready;
    const_pack::offset_word_t offsets;
    prbs_pack::prbs_cfg_t     cfg;
    logic [`CORE_NTI-1:0]     bits;
    logic                     out_valid;
    logic                     out_ready;
    prbs_pack::prbs_stat_t    stat;

    // model of expected words, their input cycles, PRBS state and counters
    logic [`CORE_NTI-1:0] exp_q[$];
    int                   cyc_q[$];
    logic [`CORE_NTI-1:0] new_bits;
    int                   in_cycle;
    logic [NP-1:0]        m_state = '0;
    longint               m_correct = 0;
    longint               m_total = 0;
    logic [NP-1:0]        gen_state = 7'h5a;
    int                   flip_cnt = 0;
    int                   err_cnt = 0;
    int                   check_cnt = 0;
    int                   test_cnt = 0;
    int                   bad_tests = 0;
    int                   test_errs = 0;
    int                   cycle_cnt = 0;
    bit                   check_lat = 1'b0;

    tb_clock_gen u_clk (.clk_o(clk), .rst_o(rst));

    digital_core u_dut (
        .clk_adc     (clk),
        .rst_i       (rst),
        .in_word_i   (in_word),
        .in_valid_i  (in_valid),
        .in_ready_o  (in_ready),
        .offsets_i   (offsets),
        .cfg_i       (cfg),
        .bits_o      (bits),
        .out_valid_o (out_valid),
        .out_ready_i (out_ready),
        .stat_o      (stat)
    );

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        check_cnt++;
        if (actual !== expected) begin
            err_cnt++;
            $display("FAILED at %0t ns: %s, got %0d, expected %0d", $time, what, actual,
                     expected);
        end
    endtask

    task automatic finish_test(input string name);
        test_cnt++;
        if (err_cnt != test_errs) begin
            bad_tests++;
        end
        $display("test %0d, %s: %s", test_cnt, name, (err_cnt == test_errs) ? "pass" : "fail");
        test_errs = err_cnt;
    endtask

    // sign-magnitude to signed, minus offset, clipped, then sliced
    function automatic logic [`CORE_NTI-1:0] model_bits(input const_pack::adc_word_t w,
            input const_pack::offset_word_t offs, input const_pack::unfolded_t thresh);
        logic [`CORE_NTI-1:0] res;
        int                   v;
        for (int k = 0; k < `CORE_NTI; k++) begin
            v = int'(w[k].mag);
            if (w[k].sign) begin
                v = -v;
            end
            v = v - int'($signed(offs[k]));
            v = (v > VMAX) ? VMAX : ((v < VMIN) ? VMIN : v);
            res[k] = v > int'($signed(thresh));
        end
        return res;
    endfunction

    task automatic model_counters(input logic [`CORE_NTI-1:0] b,
                                  input prbs_pack::prbs_mode_e mode);
        logic p;
        for (int k = 0; k < `CORE_NTI; k++) begin
            p = m_state[NP-1] ^ m_state[NP-2];
            if (mode == prbs_pack::MODE_CHECK) begin
                m_correct += (b[k] == p);
                m_state = {m_state[NP-2:0], p};
            end else begin
                m_state = {m_state[NP-2:0], b[k]};
            end
        end
        if (mode == prbs_pack::MODE_CHECK) begin
            m_total += `CORE_NTI;
        end
    endtask

    function automatic const_pack::adc_word_t rand_word();
        const_pack::adc_word_t w;
        for (int k = 0; k < `CORE_NTI; k++) begin
            w[k].sign = $urandom_range(1, 0);
            // full scale now and then to reach the clip limits
            w[k].mag  = ($urandom_range(3, 0) == 0) ? VMAX : $urandom_range(VMAX, 0);
        end
        return w;
    endfunction

    function automatic const_pack::unfolded_t pick_offset();
        case ($urandom_range(3, 0))
            0: return const_pack::unfolded_t'(VMIN);
            1: return const_pack::unfolded_t'(VMAX);
            default: return const_pack::unfolded_t'($urandom_range(255, 0));
        endcase
    endfunction

    // next four PRBS7 bits as codes with optional flips
    task automatic prbs_word(input bit with_flips, output const_pack::adc_word_t w);
        logic b;
        for (int k = 0; k < `CORE_NTI; k++) begin
            b = gen_state[NP-1] ^ gen_state[NP-2];
            gen_state = {gen_state[NP-2:0], b};
            if (with_flips && $urandom_range(15, 0) == 0) begin
                b = !b;
                flip_cnt++;
            end
            w[k].sign = !b;
            w[k].mag  = b ? $urandom_range(VMAX, 1) : $urandom_range(VMAX, 0);
        end
    endtask

    task automatic send_word(input const_pack::adc_word_t w, input int gaps,
                             input bit rand_ready);
        bit taken;
        repeat (gaps) begin
            in_valid = 1'b0;
            if (rand_ready) out_ready = $urandom_range(1, 0);
            @(negedge clk);
        end
        in_word  = w;
        in_valid = 1'b1;
        taken    = 1'b0;
        while (!taken) begin
            if (rand_ready) out_ready = $urandom_range(1, 0);
            @(posedge clk);
            taken = in_ready;
            @(negedge clk);
        end
    endtask

    task automatic drain(input bit rand_ready);
        int n;
        n = 0;
        in_valid = 1'b0;
        while ((exp_q.size() != 0 || out_valid) && n < DRAIN_MAX) begin
            if (rand_ready) out_ready = $urandom_range(1, 0);
            @(negedge clk);
            n++;
        end
        if (n == DRAIN_MAX) begin
            err_cnt++;
            $display("pipeline did not drain within %0d cycles at %0t ns", DRAIN_MAX, $time);
        end
        out_ready = 1'b1;
    endtask

    // transfers seen at the rising edge with the output side first
    always @(posedge clk) begin
        cycle_cnt++;
        if (!rst && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                err_cnt++;
                $display("extra output word at %0t ns with no input left to match", $time);
            end else begin
                check_value(bits, exp_q.pop_front(), "bits_o against model");
                in_cycle = cyc_q.pop_front();
                if (check_lat) begin
                    check_value(cycle_cnt - in_cycle, 3, "input to output latency");
                end
            end
        end
        if (!rst && in_valid && in_ready) begin
            new_bits = model_bits(in_word, offsets, cfg.thresh);
            exp_q.push_back(new_bits);
            cyc_q.push_back(cycle_cnt);
            model_counters(new_bits, cfg.mode);
        end
    end

    initial begin
        const_pack::adc_word_t w;
        longint                base_diff;
        int                    assert_errs;
        void'($urandom(32'h58331d14));
        in_word    = '0;
        in_valid   = 1'b0;
        offsets    = '0;
        cfg.mode   = prbs_pack::MODE_LOCK;
        cfg.thresh = '0;
        out_ready  = 1'b1;

        wait (rst === 1'b0);
        @(negedge clk);
        check_value(out_valid, 0, "out_valid_o after reset");
        check_value(stat, 0, "stat_o after reset");
        check_value(in_ready, 1, "in_ready_o after reset");
        finish_test("reset values");

        for (int half = 0; half < 2; half++) begin
            for (int k = 0; k < `CORE_NTI; k++) offsets[k] = pick_offset();
            cfg.thresh = $urandom_range(255, 0);
            for (int i = 0; i < 100; i++) send_word(rand_word(), 0, 1'b0);
            drain(1'b0);
        end
        finish_test("random words with saturation");

        check_lat = 1'b1;
        for (int i = 0; i < 20; i++) send_word(rand_word(), 0, 1'b0);
        drain(1'b0);
        check_lat = 1'b0;
        finish_test("three cycle latency");

        for (int k = 0; k < `CORE_NTI; k++) offsets[k] = pick_offset();
        cfg.thresh = $urandom_range(255, 0);
        for (int i = 0; i < 200; i++) send_word(rand_word(), $urandom_range(3, 0), 1'b1);
        drain(1'b1);
        finish_test("back-pressure and gaps");

        // lock on two clean words then check
        offsets    = '0;
        cfg.thresh = '0;
        for (int i = 0; i < 2; i++) begin
            prbs_word(1'b0, w);
            send_word(w, 0, 1'b0);
        end
        drain(1'b0);
        cfg.mode = prbs_pack::MODE_CHECK;
        for (int i = 0; i < 100; i++) begin
            prbs_word(1'b0, w);
            send_word(w, 0, 1'b0);
        end
        drain(1'b0);
        check_value(stat.correct, stat.total, "correct against total on clean stream");
        check_value(stat.total, 400, "total bits on clean stream");
        check_value(stat.correct, m_correct, "correct against model");
        finish_test("clean PRBS7 stream");

        base_diff  = stat.total - stat.correct;
        flip_cnt   = 0;
        cfg.mode   = prbs_pack::MODE_LOCK;
        for (int i = 0; i < 2; i++) begin
            prbs_word(1'b0, w);
            send_word(w, 0, 1'b0);
        end
        drain(1'b0);
        cfg.mode = prbs_pack::MODE_CHECK;
        for (int i = 0; i < 100; i++) begin
            prbs_word(1'b1, w);
            send_word(w, 0, 1'b0);
        end
        drain(1'b0);
        check_value(stat.total - stat.correct - base_diff, flip_cnt, "bit errors against flips");
        check_value(stat.correct, m_correct, "correct against model");
        check_value(stat.total, m_total, "total against model");
        finish_test("PRBS7 stream with flipped bits");

        assert_errs = u_dut.u_asserts.fail_cnt;
        $display("%0d tests run, %0d with errors, %0d checks, %0d errors, %0d assertion failures",
                 test_cnt, bad_tests, check_cnt, err_cnt, assert_errs);
        if (err_cnt == 0 && assert_errs == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // about twenty cycles per word covers gaps and stalls
    initial begin
        #(TOTAL_WORDS * 20 * CLK_NS);
        $display("timeout: the run did not finish within %0d cycles", TOTAL_WORDS * 20);
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+include
source/const_pack.sv
source/prbs_pack.sv
source/adc_retimer.sv
source/adc_unfolding.sv
source/prbs_checker.sv
source/digital_core.sv
verification/tb_clock_gen.sv
verification/digital_core_asserts.sv
verification/digital_core_tb.sv

/* Bender.yml */
package:
  name: digital_core

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/const_pack.sv
      - source/prbs_pack.sv
      - source/adc_retimer.sv
      - source/adc_unfolding.sv
      - source/prbs_checker.sv
      - source/digital_core.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/tb_clock_gen.sv
      - verification/digital_core_asserts.sv
      - verification/digital_core_tb.sv
